// ==== compile.f ====
logic/dma_node_pkg.sv
logic/dma_job_queue.sv
logic/dma_copy_engine.sv
logic/dma_addr_router.sv
logic/dma_local_mem.sv
logic/dma_node_top.sv
testbench/dma_node_chk.sv
testbench/tb_dma_node.sv

// ==== Makefile ====
# Verilator flow for the DMA endpoint node

VERILATOR ?= verilator
TOP       ?= tb_dma_node
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_dma_node.sv ====
// ----------------------------------------------------------
// DMA endpoint node testbench
// job stimulus, external memory model and reference checks
// ----------------------------------------------------------
`timescale 1ns/1ns

module tb_dma_node;

  localparam int unsigned TIMEOUT = 5000;

  logic                clk_i;
  logic                arst_n_i;
  logic                job_push_i;
  dma_node_pkg::addr_t job_src_i;
  dma_node_pkg::addr_t job_dst_i;
  dma_node_pkg::len_t  job_len_i;
  dma_node_pkg::data_t ext_rdata_i;
  logic                ext_rvalid_i;
  logic                job_full_o;
  logic                done_o;
  logic                err_o;
  logic                busy_o;
  logic                ext_rd_o;
  logic                ext_wr_o;
  dma_node_pkg::addr_t ext_addr_o;
  dma_node_pkg::data_t ext_wdata_o;

  // external memory as seen by the DUT, and the reference copies
  dma_node_pkg::data_t ext_mem [dma_node_pkg::addr_t];
  dma_node_pkg::data_t ref_ext [dma_node_pkg::addr_t];
  dma_node_pkg::data_t ref_local [dma_node_pkg::MEM_WORDS];
  dma_node_pkg::addr_t exp_wr_addr [$];
  dma_node_pkg::data_t exp_wr_data [$];
  logic                exp_err [$];

  logic [31:0]         rng;
  int unsigned         mismatches = 0;
  int unsigned         failures = 0;
  int unsigned         done_cnt = 0;
  int unsigned         strobe_cnt = 0;
  logic                busy_q = 1'b0;
  int unsigned         lat;
  dma_node_pkg::addr_t rd_addr;
  string               test_name;

  dma_node_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic in_window(input dma_node_pkg::addr_t a);
    return (a >= dma_node_pkg::MEM_BASE) &&
           (a < dma_node_pkg::MEM_BASE + dma_node_pkg::addr_t'(dma_node_pkg::MEM_WORDS));
  endfunction

  // copy rule: ascending words, each read at src+i then written at dst+i
  function automatic void apply_job(input dma_node_pkg::addr_t src,
                                    input dma_node_pkg::addr_t dst,
                                    input dma_node_pkg::len_t len);
    dma_node_pkg::addr_t s;
    dma_node_pkg::addr_t d;
    dma_node_pkg::data_t v;
    for (int i = 0; i < int'(len); i++) begin
      s = src + dma_node_pkg::addr_t'(i);
      d = dst + dma_node_pkg::addr_t'(i);
      if (in_window(s)) begin
        v = ref_local[dma_node_pkg::mem_addr_t'(s - dma_node_pkg::MEM_BASE)];
      end else begin
        v = ref_ext[s];
      end
      if (in_window(d)) begin
        ref_local[dma_node_pkg::mem_addr_t'(d - dma_node_pkg::MEM_BASE)] = v;
      end else begin
        ref_ext[d] = v;
        exp_wr_addr.push_back(d);
        exp_wr_data.push_back(v);
      end
    end
  endfunction

  // random window, either inside local memory or in the prefilled external area
  function automatic dma_node_pkg::addr_t pick_window();
    logic [31:0] r;
    r = next_random();
    if (r[0]) begin
      return dma_node_pkg::MEM_BASE + dma_node_pkg::addr_t'(r[15:8] % 8'd248);
    end
    return 16'h0400 + dma_node_pkg::addr_t'(r[17:9]);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    mismatches++;
    $display("ERROR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
  endtask

  task automatic push_job(input dma_node_pkg::addr_t src, input dma_node_pkg::addr_t dst,
                          input dma_node_pkg::len_t len, input logic accept);
    @(posedge clk_i);
    #2;
    job_push_i = 1'b1;
    job_src_i  = src;
    job_dst_i  = dst;
    job_len_i  = len;
    if (accept) begin
      apply_job(src, dst, len);
      exp_err.push_back(len == '0);
    end
  endtask

  task automatic end_push();
    @(posedge clk_i);
    #2;
    job_push_i = 1'b0;
  endtask

  task automatic wait_idle(input int unsigned target);
    int unsigned n;
    n = 0;
    while ((done_cnt < target || busy_o) && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    assert (n < TIMEOUT) else begin
      failures++;
      $display("timeout in %s: the node never went idle after its jobs", test_name);
    end
  endtask

  task automatic wait_not_full();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (job_full_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    #1;
    assert (n < TIMEOUT) else begin
      failures++;
      $display("timeout in %s: the job queue stayed full", test_name);
    end
  endtask

  // ----------------------------------------------------------
  // external memory model and output monitor
  // ----------------------------------------------------------
  always @(negedge clk_i) begin
    if (ext_rd_o) begin
      rd_addr = ext_addr_o;
      lat = 1 + next_random() % 4;
      repeat (lat) @(posedge clk_i);
      #2;
      ext_rdata_i  = ext_mem[rd_addr];
      ext_rvalid_i = 1'b1;
      @(posedge clk_i);
      #2;
      ext_rvalid_i = 1'b0;
    end
  end

  always @(negedge clk_i) begin
    if (ext_rd_o || ext_wr_o) begin
      strobe_cnt++;
    end
    if (ext_wr_o) begin
      ext_mem[ext_addr_o] = ext_wdata_o;
      assert (exp_wr_addr.size() != 0) else begin
        failures++;
        $display("%s: external write to %h that no job asked for", test_name, ext_addr_o);
      end
      if (exp_wr_addr.size() != 0) begin
        assert (ext_addr_o == exp_wr_addr[0])
          else report_mismatch("write address", 32'(exp_wr_addr[0]), 32'(ext_addr_o));
        assert (ext_wdata_o == exp_wr_data[0])
          else report_mismatch("write data", exp_wr_data[0], ext_wdata_o);
        void'(exp_wr_addr.pop_front());
        void'(exp_wr_data.pop_front());
      end
    end
    if (done_o) begin
      done_cnt++;
      assert (exp_err.size() != 0) else begin
        failures++;
        $display("%s: done pulse without a pending job", test_name);
      end
      if (exp_err.size() != 0) begin
        assert (err_o == exp_err[0]) else report_mismatch("err_o", 32'(exp_err[0]), 32'(err_o));
        void'(exp_err.pop_front());
      end
    end
    // busy may only drop once every accepted job has completed
    if (busy_q && !busy_o) begin
      assert (exp_err.size() == 0) else begin
        failures++;
        $display("%s: busy_o fell while jobs were still pending", test_name);
      end
    end
    busy_q = busy_o;
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  initial begin
    int unsigned         target;
    int unsigned         strobes;
    int unsigned         total;
    dma_node_pkg::data_t orig [5];
    dma_node_pkg::addr_t src;
    dma_node_pkg::addr_t dst;
    dma_node_pkg::len_t  len;
    arst_n_i     = 1'b0;
    job_push_i   = 1'b0;
    job_src_i    = '0;
    job_dst_i    = '0;
    job_len_i    = '0;
    ext_rdata_i  = '0;
    ext_rvalid_i = 1'b0;
    rng          = 32'hdfb9dd03;
    for (int a = 0; a < 32'h0800; a++) begin
      ext_mem[dma_node_pkg::addr_t'(a)] = next_random();
      ref_ext[dma_node_pkg::addr_t'(a)] = ext_mem[dma_node_pkg::addr_t'(a)];
    end
    test_name = "reset";
    repeat (5) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    assert ({job_full_o, done_o, err_o, busy_o, ext_rd_o, ext_wr_o} == 6'b0)
      else report_mismatch("idle outputs", 32'h0,
                           32'({job_full_o, done_o, err_o, busy_o, ext_rd_o, ext_wr_o}));

    test_name = "ext_to_ext";
    push_job(16'h0020, 16'h0300, 8'd6, 1'b1);
    end_push();
    wait_idle(done_cnt + 1);
    assert (exp_wr_addr.size() == 0) else report_mismatch("writes left", 0, exp_wr_addr.size());

    test_name = "zero_len";
    strobes = strobe_cnt;
    push_job(16'h0040, 16'h0700, 8'd0, 1'b1);
    end_push();
    wait_idle(done_cnt + 1);
    assert (strobe_cnt == strobes) else report_mismatch("ext strobes", strobes, strobe_cnt);

    // fill the window so later local reads see known data
    test_name = "preload";
    push_job(16'h0000, dma_node_pkg::MEM_BASE, 8'd255, 1'b1);
    end_push();
    wait_idle(done_cnt + 1);

    test_name = "round_trip";
    for (int i = 0; i < 5; i++) begin
      orig[i] = ref_ext[16'h0100 + dma_node_pkg::addr_t'(i)];
    end
    target = done_cnt + 2;
    push_job(16'h0100, 16'h1010, 8'd5, 1'b1);
    push_job(16'h1010, 16'h0600, 8'd5, 1'b1);
    end_push();
    wait_idle(target);
    for (int i = 0; i < 5; i++) begin
      assert (ext_mem[16'h0600 + dma_node_pkg::addr_t'(i)] == orig[i])
        else report_mismatch("copied word", orig[i],
                             ext_mem[16'h0600 + dma_node_pkg::addr_t'(i)]);
    end

    // long job keeps the engine busy while the queue fills
    test_name = "back_pressure";
    target = done_cnt + 5;
    push_job(16'h0200, 16'h0500, 8'd8, 1'b1);
    end_push();
    for (int j = 0; j < 4; j++) begin
      push_job(16'h0210 + dma_node_pkg::addr_t'(4 * j),
               16'h0520 + dma_node_pkg::addr_t'(4 * j), 8'd4, 1'b1);
    end
    push_job(16'h0230, 16'h0540, 8'd4, 1'b0);
    @(negedge clk_i);
    assert (job_full_o) else report_mismatch("job_full_o", 1, 32'(job_full_o));
    end_push();
    wait_idle(target);
    assert (done_cnt == target) else report_mismatch("done pulses", target, done_cnt);

    test_name = "random_mix";
    target = done_cnt + 12;
    for (int j = 0; j < 12; j++) begin
      len = dma_node_pkg::len_t'(1 + next_random() % 8);
      src = pick_window();
      dst = pick_window();
      push_job(src, dst, len, 1'b1);
      end_push();
      wait_not_full();
    end
    wait_idle(target);
    assert (done_cnt == target) else report_mismatch("done pulses", target, done_cnt);

    // copy the window out so every local word is compared
    test_name = "local_readback";
    target = done_cnt + 1;
    push_job(dma_node_pkg::MEM_BASE, 16'h0700, 8'd255, 1'b1);
    end_push();
    wait_idle(target);
    assert (exp_wr_addr.size() == 0) else report_mismatch("writes left", 0, exp_wr_addr.size());

    total = mismatches + failures + dut0.u_chk.fail_cnt;
    $display("closing counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut0.u_chk.fail_cnt);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== testbench/dma_node_chk.sv ====
// ----------------------------------------------------------
// DMA node protocol checker
// bound into the top level, watches external strobes,
// completion pulses and the engine state
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_node_chk (
  input logic                        clk_i,
  input logic                        arst_n_i,
  input logic                        job_full_i,
  input logic                        done_i,
  input logic                        err_i,
  input logic                        ext_rd_i,
  input logic                        ext_wr_i,
  input dma_node_pkg::engine_state_e state_i
);

  int unsigned fail_cnt = 0;

  // one access per cycle on the external port
  ext_excl_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ext_rd_i && ext_wr_i))
    else begin
      fail_cnt++;
      $error("external read and write strobes high in the same cycle");
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done pulse longer than one cycle");
    end

  err_with_done_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_i |-> done_i)
    else begin
      fail_cnt++;
      $error("error flag outside a done pulse");
    end

  // port stays quiet while reset is held
  reset_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> !(ext_rd_i || ext_wr_i))
    else begin
      fail_cnt++;
      $error("external strobe during reset");
    end

  // a full queue still hands its head to an idle engine
  full_state_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    job_full_i && state_i == dma_node_pkg::IDLE |=> state_i == dma_node_pkg::CHECK)
    else begin
      fail_cnt++;
      $error("idle engine did not take a job from the full queue");
    end

endmodule

bind dma_node_top dma_node_chk u_chk (
  .clk_i      ( clk_i            ),
  .arst_n_i   ( arst_n_i         ),
  .job_full_i ( job_full_o       ),
  .done_i     ( done_o           ),
  .err_i      ( err_o            ),
  .ext_rd_i   ( ext_rd_o         ),
  .ext_wr_i   ( ext_wr_o         ),
  .state_i    ( u_engine.state_q )
);

// ==== logic/dma_node_top.sv ====
// ----------------------------------------------------------
// DMA endpoint node top level
// job queue, copy engine, address router and local memory
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_node_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 job_push_i,
  input  dma_node_pkg::addr_t  job_src_i,
  input  dma_node_pkg::addr_t  job_dst_i,
  input  dma_node_pkg::len_t   job_len_i,
  input  dma_node_pkg::data_t  ext_rdata_i,
  input  logic                 ext_rvalid_i,
  output logic                 job_full_o,
  output logic                 done_o,
  output logic                 err_o,
  output logic                 busy_o,
  output logic                 ext_rd_o,
  output logic                 ext_wr_o,
  output dma_node_pkg::addr_t  ext_addr_o,
  output dma_node_pkg::data_t  ext_wdata_o
);

  // queue to engine
  logic                job_valid;
  logic                job_pop;
  dma_node_pkg::addr_t head_src;
  dma_node_pkg::addr_t head_dst;
  dma_node_pkg::len_t  head_len;

  // engine to router
  logic                acc_rd;
  logic                acc_wr;
  dma_node_pkg::addr_t acc_addr;
  dma_node_pkg::data_t acc_wdata;
  dma_node_pkg::data_t acc_rdata;
  logic                acc_rvalid;
  logic                engine_active;

  // router to memory
  logic                    mem_rd;
  logic                    mem_wr;
  dma_node_pkg::mem_addr_t mem_addr;
  dma_node_pkg::data_t     mem_wdata;
  dma_node_pkg::data_t     mem_rdata;

  // busy until the engine is idle and nothing waits in the queue
  assign busy_o = engine_active | job_valid;

  dma_job_queue u_queue (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .push_i     ( job_push_i ),
    .src_i      ( job_src_i  ),
    .dst_i      ( job_dst_i  ),
    .len_i      ( job_len_i  ),
    .pop_i      ( job_pop    ),
    .full_o     ( job_full_o ),
    .valid_o    ( job_valid  ),
    .head_src_o ( head_src   ),
    .head_dst_o ( head_dst   ),
    .head_len_o ( head_len   )
  );

  dma_copy_engine u_engine (
    .clk_i       ( clk_i         ),
    .arst_n_i    ( arst_n_i      ),
    .job_valid_i ( job_valid     ),
    .job_src_i   ( head_src      ),
    .job_dst_i   ( head_dst      ),
    .job_len_i   ( head_len      ),
    .rdata_i     ( acc_rdata     ),
    .rvalid_i    ( acc_rvalid    ),
    .job_pop_o   ( job_pop       ),
    .rd_o        ( acc_rd        ),
    .wr_o        ( acc_wr        ),
    .addr_o      ( acc_addr      ),
    .wdata_o     ( acc_wdata     ),
    .done_o      ( done_o        ),
    .err_o       ( err_o         ),
    .active_o    ( engine_active )
  );

  dma_addr_router u_router (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .rd_i         ( acc_rd       ),
    .wr_i         ( acc_wr       ),
    .addr_i       ( acc_addr     ),
    .wdata_i      ( acc_wdata    ),
    .mem_rdata_i  ( mem_rdata    ),
    .ext_rdata_i  ( ext_rdata_i  ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .rdata_o      ( acc_rdata    ),
    .rvalid_o     ( acc_rvalid   ),
    .mem_rd_o     ( mem_rd       ),
    .mem_wr_o     ( mem_wr       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_wdata_o  ( mem_wdata    ),
    .ext_rd_o     ( ext_rd_o     ),
    .ext_wr_o     ( ext_wr_o     ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_wdata_o  ( ext_wdata_o  )
  );

  dma_local_mem u_mem (
    .clk_i   ( clk_i     ),
    .rd_i    ( mem_rd    ),
    .wr_i    ( mem_wr    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

// ==== logic/dma_local_mem.sv ====
// ----------------------------------------------------------
// DMA node local memory
// single port word array, registered read data
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_local_mem (
  input  logic                     clk_i,
  input  logic                     rd_i,
  input  logic                     wr_i,
  input  dma_node_pkg::mem_addr_t  addr_i,
  input  dma_node_pkg::data_t      wdata_i,
  output dma_node_pkg::data_t      rdata_o
);

  dma_node_pkg::data_t mem_q [dma_node_pkg::MEM_WORDS];

  // write lands on the edge
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// ==== logic/dma_addr_router.sv ====
// ----------------------------------------------------------
// DMA address router
// sends window hits to local memory, the rest to the external
// port, and steers read data back from the pending target
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_addr_router (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     rd_i,
  input  logic                     wr_i,
  input  dma_node_pkg::addr_t      addr_i,
  input  dma_node_pkg::data_t      wdata_i,
  input  dma_node_pkg::data_t      mem_rdata_i,
  input  dma_node_pkg::data_t      ext_rdata_i,
  input  logic                     ext_rvalid_i,
  output dma_node_pkg::data_t      rdata_o,
  output logic                     rvalid_o,
  output logic                     mem_rd_o,
  output logic                     mem_wr_o,
  output dma_node_pkg::mem_addr_t  mem_addr_o,
  output dma_node_pkg::data_t      mem_wdata_o,
  output logic                     ext_rd_o,
  output logic                     ext_wr_o,
  output dma_node_pkg::addr_t      ext_addr_o,
  output dma_node_pkg::data_t      ext_wdata_o
);

  dma_node_pkg::addr_t offset;
  logic                is_local;

  // pending read bookkeeping
  logic rd_pend_q;
  logic rd_local_q;
  logic mem_rvalid_q;

  // below the base the subtraction wraps high, so one check covers both ends
  assign offset   = addr_i - dma_node_pkg::MEM_BASE;
  assign is_local = (offset[dma_node_pkg::ADDR_W-1:dma_node_pkg::MEM_AW] == '0);

  assign mem_rd_o    = rd_i & is_local;
  assign mem_wr_o    = wr_i & is_local;
  assign mem_addr_o  = offset[dma_node_pkg::MEM_AW-1:0];
  assign mem_wdata_o = wdata_i;

  assign ext_rd_o    = rd_i & ~is_local;
  assign ext_wr_o    = wr_i & ~is_local;
  assign ext_addr_o  = addr_i;
  assign ext_wdata_o = wdata_i;

  // only the recorded target may answer
  assign rvalid_o = rd_pend_q & (rd_local_q ? mem_rvalid_q : ext_rvalid_i);
  assign rdata_o  = rd_local_q ? mem_rdata_i : ext_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_pend_q    <= 1'b0;
      rd_local_q   <= 1'b0;
      mem_rvalid_q <= 1'b0;
    end else begin
      // memory data is registered, valid follows one cycle later
      mem_rvalid_q <= mem_rd_o;
      if (rd_i) begin
        rd_pend_q  <= 1'b1;
        rd_local_q <= is_local;
      end else if (rvalid_o) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/dma_copy_engine.sv ====
// ----------------------------------------------------------
// DMA copy engine
// takes one job at a time, rejects zero lengths and copies
// word by word with a single read in flight
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_copy_engine (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 job_valid_i,
  input  dma_node_pkg::addr_t  job_src_i,
  input  dma_node_pkg::addr_t  job_dst_i,
  input  dma_node_pkg::len_t   job_len_i,
  input  dma_node_pkg::data_t  rdata_i,
  input  logic                 rvalid_i,
  output logic                 job_pop_o,
  output logic                 rd_o,
  output logic                 wr_o,
  output dma_node_pkg::addr_t  addr_o,
  output dma_node_pkg::data_t  wdata_o,
  output logic                 done_o,
  output logic                 err_o,
  output logic                 active_o
);

  dma_node_pkg::engine_state_e state_q;
  dma_node_pkg::engine_state_e state_d;

  // latched job and captured word
  dma_node_pkg::addr_t src_q;
  dma_node_pkg::addr_t dst_q;
  dma_node_pkg::len_t  len_q;
  dma_node_pkg::data_t word_q;

  dma_node_pkg::len_t  idx_q;
  logic                err_q;
  logic                last_word;
  dma_node_pkg::addr_t idx_ext;

  assign idx_ext   = dma_node_pkg::addr_t'(idx_q);
  assign last_word = (idx_q == len_q - dma_node_pkg::len_t'(1));

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      dma_node_pkg::IDLE: begin
        if (job_valid_i) begin
          state_d = dma_node_pkg::CHECK;
        end
      end
      dma_node_pkg::CHECK: begin
        // zero-length jobs are answered with an error completion
        if (len_q == '0) begin
          state_d = dma_node_pkg::DONE;
        end else begin
          state_d = dma_node_pkg::READ;
        end
      end
      dma_node_pkg::READ: state_d = dma_node_pkg::WAIT_DATA;
      dma_node_pkg::WAIT_DATA: begin
        if (rvalid_i) begin
          state_d = dma_node_pkg::WRITE;
        end
      end
      dma_node_pkg::WRITE: begin
        if (last_word) begin
          state_d = dma_node_pkg::DONE;
        end else begin
          state_d = dma_node_pkg::READ;
        end
      end
      dma_node_pkg::DONE: state_d = dma_node_pkg::IDLE;
      default: state_d = dma_node_pkg::IDLE;
    endcase
  end

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= dma_node_pkg::IDLE;
      idx_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == dma_node_pkg::CHECK) begin
        idx_q <= '0;
        err_q <= (len_q == '0);
      end else if (state_q == dma_node_pkg::WRITE) begin
        idx_q <= idx_q + dma_node_pkg::len_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_pop_o) begin
      src_q <= job_src_i;
      dst_q <= job_dst_i;
      len_q <= job_len_i;
    end
    if (state_q == dma_node_pkg::WAIT_DATA && rvalid_i) begin
      word_q <= rdata_i;
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign job_pop_o = (state_q == dma_node_pkg::IDLE) && job_valid_i;
  assign rd_o      = (state_q == dma_node_pkg::READ);
  assign wr_o      = (state_q == dma_node_pkg::WRITE);
  // write phase uses the destination, all else the source
  assign addr_o    = wr_o ? (dst_q + idx_ext) : (src_q + idx_ext);
  assign wdata_o   = word_q;
  assign done_o    = (state_q == dma_node_pkg::DONE);
  assign err_o     = done_o & err_q;
  assign active_o  = (state_q != dma_node_pkg::IDLE);

endmodule

// ==== logic/dma_job_queue.sv ====
// ----------------------------------------------------------
// DMA job queue
// small FIFO of transfer descriptors, head shown to the engine
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_job_queue (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 push_i,
  input  dma_node_pkg::addr_t  src_i,
  input  dma_node_pkg::addr_t  dst_i,
  input  dma_node_pkg::len_t   len_i,
  input  logic                 pop_i,
  output logic                 full_o,
  output logic                 valid_o,
  output dma_node_pkg::addr_t  head_src_o,
  output dma_node_pkg::addr_t  head_dst_o,
  output dma_node_pkg::len_t   head_len_o
);

  // descriptor storage
  dma_node_pkg::addr_t src_q [dma_node_pkg::QUEUE_DEPTH];
  dma_node_pkg::addr_t dst_q [dma_node_pkg::QUEUE_DEPTH];
  dma_node_pkg::len_t  len_q [dma_node_pkg::QUEUE_DEPTH];

  dma_node_pkg::qptr_t wr_ptr_q;
  dma_node_pkg::qptr_t rd_ptr_q;
  dma_node_pkg::qcnt_t count_q;

  logic do_push;
  logic do_pop;

  assign full_o  = (count_q == dma_node_pkg::qcnt_t'(dma_node_pkg::QUEUE_DEPTH));
  assign valid_o = (count_q != '0);

  // a push while full is lost
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;

  assign head_src_o = src_q[rd_ptr_q];
  assign head_dst_o = dst_q[rd_ptr_q];
  assign head_len_o = len_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      src_q[wr_ptr_q] <= src_i;
      dst_q[wr_ptr_q] <= dst_i;
      len_q[wr_ptr_q] <= len_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // occupancy only moves when exactly one side acts
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== logic/dma_node_pkg.sv ====
// ----------------------------------------------------------
// DMA endpoint node shared definitions
// widths, local memory window, queue sizing and engine states
// ----------------------------------------------------------

package dma_node_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned LEN_W  = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  // at most 255 words per job
  typedef logic [LEN_W-1:0]  len_t;

  // ----------------------------------------------------------
  // descriptor queue
  // ----------------------------------------------------------
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);

  // pointers wrap on their own, depth is a power of two
  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QPTR_W:0]   qcnt_t;

  // ----------------------------------------------------------
  // local memory window
  // ----------------------------------------------------------
  localparam addr_t       MEM_BASE  = 16'h1000;
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  // word offset inside the window
  typedef logic [MEM_AW-1:0] mem_addr_t;

  // copy engine FSM
  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    READ,
    WAIT_DATA,
    WRITE,
    DONE
  } engine_state_e;

endpackage
